// File: test/decode_input.txt
# name instr(hex) pc(hex) instr_id(dec) rd(dec) imm(hex) flags(bin)
# flags are rs1_re rs2_re rd_we mem_re mem_we
addi       00510093 00000100 0  1  00000005 10100
slti_neg   fff22193 00000104 1  3  ffffffff 10100
sltiu      7ff33293 00000108 2  5  000007ff 10100
xori_x0    80004393 0000010c 3  7  fffff800 10100
ori        1234e413 00000110 4  8  00000123 10100
andi       0f05f513 00000114 5  10 000000f0 10100
slli       00369613 00000118 6  12 00000003 10100
srli       0047d713 0000011c 7  14 00000004 10100
srai       4078d813 00000120 8  16 00000407 10100
add        003100b3 00000124 9  1  00000000 11100
sub        40628233 00000128 10 4  00000000 11100
sll        009413b3 0000012c 11 7  00000000 11100
slt        00c5a533 00000130 12 10 00000000 11100
sltu_x0    00e036b3 00000134 13 13 00000000 11100
xor_x0     000847b3 00000138 14 15 00000000 11100
srl        013958b3 0000013c 15 17 00000000 11100
sra        416ada33 00000140 16 20 00000000 11100
or         019c6bb3 00000144 17 23 00000000 11100
and        01cdfd33 00000148 18 26 00000000 11100
lb         008f0e83 0000014c 19 29 00000008 10110
lh_neg     ffcf9f83 00000150 20 31 fffffffc 10110
lw         10012083 00000154 21 1  00000100 10110
lbu        00124183 00000158 22 3  00000001 10110
lhu_neg    ffe35283 0000015c 23 5  fffffffe 10110
sb         007402a3 00000160 24 5  00000005 11001
sh_neg     fe951c23 00000164 25 24 fffffff8 11001
sw_x0      7e05a223 00000168 26 4  000007e4 11001
lui        abcde637 0000016c 27 12 abcde000 00100
auipc      00001697 00000170 28 13 00001000 00100
ill_opcode ffffffff 00000174 29 31 00000000 00000
ill_load   01013083 00000178 29 1  00000010 00000

// File: tb.f
hw/rv_pkg.sv
hw/pipe_reg.sv
hw/ctrl_unit.sv
hw/regfile.sv
hw/id_stage.sv
hw/decode_top.sv
test/tb_decode_top.sv

// File: test/tb_decode_top.sv
`timescale 1ns/1ps

module tb_decode_top;

    localparam int MAX_VEC = 64;

    logic                          clk_i;
    logic                          reset_i;
    logic                          if_valid_i;
    logic [rv_pkg::XLEN-1:0]       if_pc_i;
    logic [rv_pkg::INST_WIDTH-1:0] if_instr_i;
    logic                          stall_i;
    logic                          wb_we_i;
    logic [rv_pkg::GPR_ADDR_W-1:0] wb_addr_i;
    logic [rv_pkg::XLEN-1:0]       wb_data_i;
    logic                          id_ex_valid_o;
    rv_pkg::id_ex_t                id_ex_o;

    logic [8*12-1:0] vec_name  [MAX_VEC];
    logic [31:0]     vec_instr [MAX_VEC];
    logic [31:0]     vec_pc    [MAX_VEC];
    logic [31:0]     vec_imm   [MAX_VEC];
    int              vec_id    [MAX_VEC];
    int              vec_rd    [MAX_VEC];
    logic [4:0]      vec_flags [MAX_VEC];

    logic [8*12-1:0] cur_name;
    int              num_vec;
    int              n_pass;
    int              n_fail;
    int              test_errs;
    int              cycles;
    int              cycle_limit;

    decode_top UUT (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .if_valid_i   (if_valid_i),
        .if_pc_i      (if_pc_i),
        .if_instr_i   (if_instr_i),
        .stall_i      (stall_i),
        .wb_we_i      (wb_we_i),
        .wb_addr_i    (wb_addr_i),
        .wb_data_i    (wb_data_i),
        .id_ex_valid_o(id_ex_valid_o),
        .id_ex_o      (id_ex_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, no valid output from the DUT", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // register r holds 0x1000 + r * 0x11 and x0 stays zero
    function automatic logic [31:0] expected_gpr(input logic [4:0] r);
        if (r == 5'd0) begin
            return 32'h0;
        end
        return 32'h1000 + r * 32'h11;
    endfunction

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic compare_value(input string field, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("Error %0s %0s: expected %h, actual %h", cur_name, field, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            $display("%0s: ok", cur_name);
            n_pass++;
        end else begin
            $display("%0s: %0d errors", cur_name, test_errs);
            n_fail++;
        end
    endtask

    task automatic load_vectors();
        int              fd;
        int              code;
        string           line;
        logic [8*12-1:0] nm;
        logic [31:0]     ins;
        logic [31:0]     pc;
        logic [31:0]     imm;
        int              id;
        int              rd;
        logic [4:0]      fl;
        fd = $fopen("test/decode_input.txt", "r");
        if (fd == 0) begin
            $display("could not open test/decode_input.txt");
            n_fail++;
        end else begin
            while (!$feof(fd) && num_vec < MAX_VEC) begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                code = $sscanf(line, "%s %h %h %d %d %h %b", nm, ins, pc, id, rd, imm, fl);
                if (code != 7) begin
                    $display("malformed line in the vector file: %0s", line);
                    n_fail++;
                end else begin
                    vec_name[num_vec]  = nm;
                    vec_instr[num_vec] = ins;
                    vec_pc[num_vec]    = pc;
                    vec_id[num_vec]    = id;
                    vec_rd[num_vec]    = rd;
                    vec_imm[num_vec]   = imm;
                    vec_flags[num_vec] = fl;
                    num_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    // valid must stay low while the register file is filled
    task automatic check_reset_and_fill();
        cur_name  = "reset";
        test_errs = 0;
        if (id_ex_valid_o !== 1'b0) begin
            $display("reset: id_ex_valid_o is not low after reset");
            test_errs++;
        end
        for (int r = 1; r < 32; r++) begin
            wb_we_i   = 1'b1;
            wb_addr_i = r[4:0];
            wb_data_i = expected_gpr(r[4:0]);
            step();
            if (id_ex_valid_o !== 1'b0) begin
                $display("reset: id_ex_valid_o went high before any instruction");
                test_errs++;
            end
        end
        wb_we_i = 1'b0;
        finish_test();
    endtask

    task automatic run_vector(input int i);
        int         n_stall;
        int         waited;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] act_flags;
        cur_name   = vec_name[i];
        test_errs  = 0;
        n_stall    = $urandom % 4;
        rs1        = vec_instr[i][19:15];
        rs2        = vec_instr[i][24:20];
        if_valid_i = 1'b1;
        if_pc_i    = vec_pc[i];
        if_instr_i = vec_instr[i];
        stall_i    = (n_stall > 0);
        // instruction held at the input while stalled
        for (int k = 0; k < n_stall; k++) begin
            step();
            if (k == n_stall - 1) begin
                stall_i = 1'b0;
            end
            if (id_ex_valid_o !== 1'b0) begin
                $display("%0s: output valid during a stall with nothing in flight", cur_name);
                test_errs++;
            end
        end
        step();
        if_valid_i = 1'b0;
        if_pc_i    = '0;
        if_instr_i = '0;
        waited     = 0;
        while (id_ex_valid_o !== 1'b1) begin
            step();
            waited++;
        end
        compare_value("latency", 32'd1, waited);
        // ID/EX must hold the result across a stalled edge
        stall_i = 1'b1;
        step();
        stall_i = 1'b0;
        if (id_ex_valid_o !== 1'b1) begin
            $display("%0s: output valid dropped during a stall", cur_name);
            test_errs++;
        end
        compare_value("pc", vec_pc[i], id_ex_o.pc);
        compare_value("instr_id", vec_id[i], id_ex_o.ctrl.instr_id);
        compare_value("rd", vec_rd[i], id_ex_o.rd_addr);
        compare_value("rs1_addr", rs1, id_ex_o.rs1_addr);
        compare_value("rs2_addr", rs2, id_ex_o.rs2_addr);
        compare_value("rs1_val", vec_flags[i][4] ? expected_gpr(rs1) : 32'h0, id_ex_o.rs1_val);
        compare_value("rs2_val", vec_flags[i][3] ? expected_gpr(rs2) : 32'h0, id_ex_o.rs2_val);
        compare_value("imm", vec_imm[i], id_ex_o.imm);
        act_flags = {id_ex_o.ctrl.rs1_re, id_ex_o.ctrl.rs2_re, id_ex_o.ctrl.rd_we,
                     id_ex_o.ctrl.mem_re, id_ex_o.ctrl.mem_we};
        compare_value("flags", vec_flags[i], act_flags);
        step();
        if (id_ex_valid_o !== 1'b0) begin
            $display("%0s: instruction came out more than once", cur_name);
            test_errs++;
        end
        finish_test();
    endtask

    initial begin
        void'($urandom(14));
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        if_valid_i  = 1'b0;
        if_pc_i     = '0;
        if_instr_i  = '0;
        stall_i     = 1'b0;
        wb_we_i     = 1'b0;
        wb_addr_i   = '0;
        wb_data_i   = '0;
        num_vec     = 0;
        n_pass      = 0;
        n_fail      = 0;
        cycles      = 0;
        cycle_limit = 40;
        load_vectors();
        cycle_limit = 40 + 8 * num_vec;
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        check_reset_and_fill();
        for (int i = 0; i < num_vec; i++) begin
            run_vector(i);
        end
        if (num_vec == 0) begin
            $display("no test vectors were loaded");
            n_fail++;
        end
        $display("passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: hw/decode_top.sv
`timescale 1ns/1ps

module decode_top (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          if_valid_i,
    input  logic [rv_pkg::XLEN-1:0]       if_pc_i,
    input  logic [rv_pkg::INST_WIDTH-1:0] if_instr_i,
    input  logic                          stall_i,
    input  logic                          wb_we_i,
    input  logic [rv_pkg::GPR_ADDR_W-1:0] wb_addr_i,
    input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
    output logic                          id_ex_valid_o,
    output rv_pkg::id_ex_t                id_ex_o
);

    rv_pkg::if_id_t                if_id_in;
    rv_pkg::if_id_t                if_id_q;
    logic                          if_id_valid;
    logic [rv_pkg::OPCODE_W-1:0]   opcode;
    logic [rv_pkg::FUNCT3_W-1:0]   funct3;
    logic [rv_pkg::FUNCT7_W-1:0]   funct7;
    rv_pkg::ctrl_t                 ctrl;
    logic [rv_pkg::GPR_ADDR_W-1:0] rs1_addr;
    logic [rv_pkg::GPR_ADDR_W-1:0] rs2_addr;
    logic [rv_pkg::XLEN-1:0]       rs1_val;
    logic [rv_pkg::XLEN-1:0]       rs2_val;
    rv_pkg::id_ex_t                id_ex_d;

    assign if_id_in = '{pc: if_pc_i, instr: if_instr_i};

    pipe_reg #(
        .payload_t(rv_pkg::if_id_t)
    ) if_id_reg (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .stall_i(stall_i),
        .valid_i(if_valid_i),
        .data_i (if_id_in),
        .valid_o(if_id_valid),
        .data_o (if_id_q)
    );

    id_stage u_id_stage (
        .if_id_i   (if_id_q),
        .opcode_o  (opcode),
        .funct3_o  (funct3),
        .funct7_o  (funct7),
        .ctrl_i    (ctrl),
        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .id_ex_o   (id_ex_d)
    );

    ctrl_unit u_ctrl_unit (
        .opcode_i(opcode),
        .funct3_i(funct3),
        .funct7_i(funct7),
        .ctrl_o  (ctrl)
    );

    // writeback port stands in for a later stage
    regfile u_regfile (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val),
        .we_i      (wb_we_i),
        .waddr_i   (wb_addr_i),
        .wdata_i   (wb_data_i)
    );

    pipe_reg #(
        .payload_t(rv_pkg::id_ex_t)
    ) id_ex_reg (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .stall_i(stall_i),
        .valid_i(if_id_valid),
        .data_i (id_ex_d),
        .valid_o(id_ex_valid_o),
        .data_o (id_ex_o)
    );

endmodule

// File: hw/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  rv_pkg::if_id_t                if_id_i,
    output logic [rv_pkg::OPCODE_W-1:0]   opcode_o,
    output logic [rv_pkg::FUNCT3_W-1:0]   funct3_o,
    output logic [rv_pkg::FUNCT7_W-1:0]   funct7_o,
    input  rv_pkg::ctrl_t                 ctrl_i,
    output logic [rv_pkg::GPR_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_pkg::GPR_ADDR_W-1:0] rs2_addr_o,
    input  logic [rv_pkg::XLEN-1:0]       rs1_val_i,
    input  logic [rv_pkg::XLEN-1:0]       rs2_val_i,
    output rv_pkg::id_ex_t                id_ex_o
);

    logic [rv_pkg::INST_WIDTH-1:0] instr;
    logic [rv_pkg::XLEN-1:0]       imm;

    assign instr      = if_id_i.instr;
    assign opcode_o   = instr[rv_pkg::OPCODE_W-1:0];
    assign funct3_o   = instr[rv_pkg::FUNCT3_LSB +: rv_pkg::FUNCT3_W];
    assign funct7_o   = instr[rv_pkg::FUNCT7_LSB +: rv_pkg::FUNCT7_W];
    assign rs1_addr_o = instr[rv_pkg::RS1_LSB +: rv_pkg::GPR_ADDR_W];
    assign rs2_addr_o = instr[rv_pkg::RS2_LSB +: rv_pkg::GPR_ADDR_W];

    always_comb begin
        case (opcode_o)
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            rv_pkg::OPC_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
                imm = {instr[31:12], 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    always_comb begin
        id_ex_o.pc       = if_id_i.pc;
        id_ex_o.rd_addr  = instr[rv_pkg::RD_LSB +: rv_pkg::GPR_ADDR_W];
        id_ex_o.rs1_addr = rs1_addr_o;
        id_ex_o.rs2_addr = rs2_addr_o;
        // unused ports read as zero
        id_ex_o.rs1_val  = ctrl_i.rs1_re ? rs1_val_i : '0;
        id_ex_o.rs2_val  = ctrl_i.rs2_re ? rs2_val_i : '0;
        id_ex_o.imm      = imm;
        id_ex_o.ctrl     = ctrl_i;
    end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic [rv_pkg::GPR_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::GPR_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_val_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_val_o,
    input  logic                          we_i,
    input  logic [rv_pkg::GPR_ADDR_W-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]       wdata_i
);

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    function automatic logic [rv_pkg::XLEN-1:0] read_gpr(
        input logic [rv_pkg::GPR_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (we_i && addr == waddr_i) begin
            // same cycle write wins
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_val_o = read_gpr(rs1_addr_i);
        rs2_val_o = read_gpr(rs2_addr_i);
    end

endmodule

// File: hw/ctrl_unit.sv
`timescale 1ns/1ps

module ctrl_unit (
    input  logic [rv_pkg::OPCODE_W-1:0] opcode_i,
    input  logic [rv_pkg::FUNCT3_W-1:0] funct3_i,
    input  logic [rv_pkg::FUNCT7_W-1:0] funct7_i,
    output rv_pkg::ctrl_t               ctrl_o
);

    rv_pkg::instr_id_e id;
    logic              alt;

    // funct7[5] picks sub and arithmetic shifts
    assign alt = funct7_i[5];

    always_comb begin
        id = rv_pkg::ILLEGAL;
        case (opcode_i)
            rv_pkg::OPC_OP_IMM: begin
                case (funct3_i)
                    3'b000: id = rv_pkg::ADDI;
                    3'b001: id = rv_pkg::SLLI;
                    3'b010: id = rv_pkg::SLTI;
                    3'b011: id = rv_pkg::SLTIU;
                    3'b100: id = rv_pkg::XORI;
                    3'b101: id = alt ? rv_pkg::SRAI : rv_pkg::SRLI;
                    3'b110: id = rv_pkg::ORI;
                    default: id = rv_pkg::ANDI;
                endcase
            end
            rv_pkg::OPC_OP: begin
                case (funct3_i)
                    3'b000: id = alt ? rv_pkg::SUB : rv_pkg::ADD;
                    3'b001: id = rv_pkg::SLL;
                    3'b010: id = rv_pkg::SLT;
                    3'b011: id = rv_pkg::SLTU;
                    3'b100: id = rv_pkg::XOR;
                    3'b101: id = alt ? rv_pkg::SRA : rv_pkg::SRL;
                    3'b110: id = rv_pkg::OR;
                    default: id = rv_pkg::AND;
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                case (funct3_i)
                    3'b000: id = rv_pkg::LB;
                    3'b001: id = rv_pkg::LH;
                    3'b010: id = rv_pkg::LW;
                    3'b100: id = rv_pkg::LBU;
                    3'b101: id = rv_pkg::LHU;
                    default: id = rv_pkg::ILLEGAL;
                endcase
            end
            rv_pkg::OPC_STORE: begin
                case (funct3_i)
                    3'b000: id = rv_pkg::SB;
                    3'b001: id = rv_pkg::SH;
                    3'b010: id = rv_pkg::SW;
                    default: id = rv_pkg::ILLEGAL;
                endcase
            end
            rv_pkg::OPC_LUI:   id = rv_pkg::LUI;
            rv_pkg::OPC_AUIPC: id = rv_pkg::AUIPC;
            default:           id = rv_pkg::ILLEGAL;
        endcase
    end

    // enables follow the opcode once the id is known to be legal
    always_comb begin
        ctrl_o          = '0;
        ctrl_o.instr_id = id;
        if (id != rv_pkg::ILLEGAL) begin
            case (opcode_i)
                rv_pkg::OPC_OP: begin
                    ctrl_o.rs1_re = 1'b1;
                    ctrl_o.rs2_re = 1'b1;
                    ctrl_o.rd_we  = 1'b1;
                end
                rv_pkg::OPC_OP_IMM: begin
                    ctrl_o.rs1_re = 1'b1;
                    ctrl_o.rd_we  = 1'b1;
                end
                rv_pkg::OPC_LOAD: begin
                    ctrl_o.rs1_re = 1'b1;
                    ctrl_o.rd_we  = 1'b1;
                    ctrl_o.mem_re = 1'b1;
                end
                rv_pkg::OPC_STORE: begin
                    ctrl_o.rs1_re = 1'b1;
                    ctrl_o.rs2_re = 1'b1;
                    ctrl_o.mem_we = 1'b1;
                end
                default: begin
                    ctrl_o.rd_we = 1'b1;
                end
            endcase
        end
    end

endmodule

// File: hw/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     stall_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    // payload only moves when the stage advances
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            data_o <= data_i;
        end
    end

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

    localparam int INST_WIDTH = 32;
    localparam int XLEN       = 32;
    localparam int GPR_ADDR_W = 5;

    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // low bit of each instruction field
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam logic [OPCODE_W-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [5:0] {
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        LUI, AUIPC,
        ILLEGAL
    } instr_id_e;

    typedef struct packed {
        logic      rs1_re;
        logic      rs2_re;
        logic      rd_we;
        logic      mem_re;
        logic      mem_we;
        instr_id_e instr_id;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [INST_WIDTH-1:0] instr;
    } if_id_t;

    // bundle handed to execute
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [GPR_ADDR_W-1:0] rd_addr;
        logic [GPR_ADDR_W-1:0] rs1_addr;
        logic [GPR_ADDR_W-1:0] rs2_addr;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
        ctrl_t                 ctrl;
    } id_ex_t;

endpackage
